// File: flist.f
logic/bus_pkg.sv
logic/ctl_pkg.sv
logic/bank_ram.sv
logic/ctl_regs.sv
logic/cpu_bus_bridge.sv
logic/cpu_bram_top.sv
sim/bram_checker.sv
sim/tb_cpu_bram.sv

// File: Bender.yml
package:
  name: cpu_bram

sources:
  - logic/bus_pkg.sv
  - logic/ctl_pkg.sv
  - logic/bank_ram.sv
  - logic/ctl_regs.sv
  - logic/cpu_bus_bridge.sv
  - logic/cpu_bram_top.sv
  - target: simulation
    files:
      - sim/bram_checker.sv
      - sim/tb_cpu_bram.sv

// File: sim/tb_cpu_bram.sv
`timescale 1ns/1ps
module tb_cpu_bram;
  import bus_pkg::*;
  import ctl_pkg::*;

  localparam int MOD_PAGE_BITS = bus_pkg::MOD_PAGE_W;
  localparam int STM_PAGE_BITS = bus_pkg::STM_PAGE_W;
  localparam int NORMAL_WORDS = bus_pkg::NORMAL_DEPTH;
  localparam int CLK_PERIOD = 20;
  localparam int ACCESS_CYCLES = 6;
  localparam int NUM_ACCESSES = 18 + 41 + (2 * NORMAL_WORDS + 4) + 18 * (2 ** MOD_PAGE_BITS)
                                + 18 * (2 ** STM_PAGE_BITS) + 240;

  logic                      CPU_CKIO;
  logic                      rst_n;
  logic [BUS_ADDR_W+2:0]     cpu_addr;
  logic [DATA_W-1:0]         cpu_data;
  logic                      cpu_cs1_n;
  logic                      cpu_we0_n;
  logic [DATA_W-1:0]         cpu_data_read;
  logic                      force_fan;
  logic                      sync;
  logic [15:0]               mod_cycle;
  logic [31:0]               mod_freq_div;
  logic [SILENT_STEP_W-1:0]  silent_step;
  logic [15:0]               stm_cycle;
  logic [31:0]               stm_freq_div;
  logic [31:0]               sound_speed;
  logic [15:0]               stm_start_idx;
  logic [15:0]               stm_finish_idx;
  logic [63:0]               ec_sync_time;

  // Expected values handed to the checker
  logic                      rd_chk;
  logic [DATA_W-1:0]         rd_exp;
  logic                      regs_chk;
  logic                      exp_force_fan;
  logic                      exp_sync;
  logic [15:0]               exp_mod_cycle;
  logic [31:0]               exp_mod_freq_div;
  logic [SILENT_STEP_W-1:0]  exp_silent_step;
  logic [15:0]               exp_stm_cycle;
  logic [31:0]               exp_stm_freq_div;
  logic [31:0]               exp_sound_speed;
  logic [15:0]               exp_stm_start_idx;
  logic [15:0]               exp_stm_finish_idx;
  logic [63:0]               exp_ec_sync_time;
  logic                      test_done;
  int                        test_num;
  logic                      run_done;
  int                        err_total;
  logic                      reported;

  // Reference memory model
  logic [DATA_W-1:0] ctl_mem [256];
  logic [DATA_W-1:0] normal_mem [NORMAL_WORDS];
  logic [DATA_W-1:0] mod_mem [2 ** (BUS_ADDR_W + MOD_PAGE_BITS)];
  logic [DATA_W-1:0] stm_mem [2 ** (BUS_ADDR_W + STM_PAGE_BITS)];

  logic [31:0]           r;
  int unsigned           seed_val;
  bram_select_t          region;
  logic [BUS_ADDR_W-1:0] a;

  cpu_bram_top #(
    .MOD_PAGE_W(MOD_PAGE_BITS),
    .STM_PAGE_W(STM_PAGE_BITS),
    .NORMAL_DEPTH(NORMAL_WORDS)
  ) UUT (
    .CPU_CKIO(CPU_CKIO), .rst_n(rst_n),
    .cpu_addr(cpu_addr), .cpu_data(cpu_data),
    .cpu_cs1_n(cpu_cs1_n), .cpu_we0_n(cpu_we0_n),
    .cpu_data_read(cpu_data_read),
    .force_fan(force_fan), .sync(sync),
    .mod_cycle(mod_cycle), .mod_freq_div(mod_freq_div),
    .silent_step(silent_step), .stm_cycle(stm_cycle),
    .stm_freq_div(stm_freq_div), .sound_speed(sound_speed),
    .stm_start_idx(stm_start_idx), .stm_finish_idx(stm_finish_idx),
    .ec_sync_time(ec_sync_time)
  );

  bram_checker u_checker (
    .CPU_CKIO(CPU_CKIO), .cpu_addr(cpu_addr), .cpu_data_read(cpu_data_read),
    .force_fan(force_fan), .sync(sync),
    .mod_cycle(mod_cycle), .mod_freq_div(mod_freq_div),
    .silent_step(silent_step), .stm_cycle(stm_cycle),
    .stm_freq_div(stm_freq_div), .sound_speed(sound_speed),
    .stm_start_idx(stm_start_idx), .stm_finish_idx(stm_finish_idx),
    .ec_sync_time(ec_sync_time),
    .rd_chk(rd_chk), .rd_exp(rd_exp), .regs_chk(regs_chk),
    .exp_force_fan(exp_force_fan), .exp_sync(exp_sync),
    .exp_mod_cycle(exp_mod_cycle), .exp_mod_freq_div(exp_mod_freq_div),
    .exp_silent_step(exp_silent_step), .exp_stm_cycle(exp_stm_cycle),
    .exp_stm_freq_div(exp_stm_freq_div), .exp_sound_speed(exp_sound_speed),
    .exp_stm_start_idx(exp_stm_start_idx), .exp_stm_finish_idx(exp_stm_finish_idx),
    .exp_ec_sync_time(exp_ec_sync_time),
    .test_done(test_done), .test_num(test_num), .run_done(run_done),
    .err_total(err_total), .reported(reported)
  );

  always #(CLK_PERIOD / 2) CPU_CKIO = ~CPU_CKIO;

  // Bits kept by a write to a controller register
  function automatic logic [DATA_W-1:0] ctl_mask(input logic [7:0] addr);
    logic [DATA_W-1:0] m;
    case (addr)
      addr_ctl_flag:     m = (16'd1 << CTL_FLAG_FORCE_FAN_BIT) | (16'd1 << CTL_FLAG_SYNC_BIT);
      addr_mod_mem_page: m = (16'd1 << MOD_PAGE_BITS) - 16'd1;
      addr_stm_mem_page: m = (16'd1 << STM_PAGE_BITS) - 16'd1;
      addr_silent_step:  m = (16'd1 << SILENT_STEP_W) - 16'd1;
      addr_mod_cycle, addr_mod_freq_div_0, addr_mod_freq_div_1, addr_stm_cycle,
      addr_stm_freq_div_0, addr_stm_freq_div_1, addr_sound_speed_0, addr_sound_speed_1,
      addr_stm_start_idx, addr_stm_finish_idx, addr_ec_sync_time_0, addr_ec_sync_time_1,
      addr_ec_sync_time_2, addr_ec_sync_time_3: m = 16'hffff;
      default:           m = 16'h0000;
    endcase
    return m;
  endfunction

  function automatic logic [MOD_PAGE_BITS-1:0] mod_page_now();
    return ctl_mem[addr_mod_mem_page][MOD_PAGE_BITS-1:0];
  endfunction

  function automatic logic [STM_PAGE_BITS-1:0] stm_page_now();
    return ctl_mem[addr_stm_mem_page][STM_PAGE_BITS-1:0];
  endfunction

  // First four and last four words of a page
  function automatic logic [BUS_ADDR_W-1:0] edge_addr(input int i);
    if (i < 4) begin
      return BUS_ADDR_W'(i);
    end
    return BUS_ADDR_W'((1 << BUS_ADDR_W) - 8 + i);
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input bram_select_t sel,
                                                    input logic [BUS_ADDR_W-1:0] waddr);
    logic [DATA_W-1:0] value;
    case (sel)
      bram_select_controller: value = (waddr[13:8] == '0) ? ctl_mem[waddr[7:0]] : 16'h0000;
      bram_select_mod:        value = mod_mem[{mod_page_now(), waddr}];
      bram_select_normal: begin
        value = (waddr[7:0] < NORMAL_WORDS) ? normal_mem[waddr[7:0]] : 16'h0000;
      end
      default:                value = stm_mem[{stm_page_now(), waddr}];
    endcase
    return value;
  endfunction

  task automatic model_write(input bram_select_t sel, input logic [BUS_ADDR_W-1:0] waddr,
                             input logic [DATA_W-1:0] wdata);
    case (sel)
      bram_select_controller: begin
        if (waddr[13:8] == '0) begin
          ctl_mem[waddr[7:0]] = wdata & ctl_mask(waddr[7:0]);
        end
      end
      bram_select_mod: mod_mem[{mod_page_now(), waddr}] = wdata;
      bram_select_normal: begin
        if (waddr[7:0] < NORMAL_WORDS) begin
          normal_mem[waddr[7:0]] = wdata;
        end
      end
      default: stm_mem[{stm_page_now(), waddr}] = wdata;
    endcase
  endtask

  task automatic expect_read(input logic [DATA_W-1:0] value);
    rd_exp = value;
    rd_chk = 1'b1;
    @(negedge CPU_CKIO);
    rd_chk = 1'b0;
  endtask

  // Each access starts on a falling edge and ends one idle cycle later
  task automatic bus_write(input bram_select_t sel, input logic [BUS_ADDR_W-1:0] waddr,
                           input logic [DATA_W-1:0] wdata);
    cpu_addr = {sel, waddr, 1'b0};
    cpu_data = wdata;
    cpu_cs1_n = 1'b0;
    cpu_we0_n = 1'b0;
    repeat (5) @(negedge CPU_CKIO);
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    model_write(sel, waddr, wdata);
    @(negedge CPU_CKIO);
  endtask

  task automatic bus_read(input bram_select_t sel, input logic [BUS_ADDR_W-1:0] waddr);
    cpu_addr = {sel, waddr, 1'b0};
    cpu_cs1_n = 1'b0;
    cpu_we0_n = 1'b1;
    repeat (5) @(negedge CPU_CKIO);
    cpu_cs1_n = 1'b1;
    expect_read(model_read(sel, waddr));
  endtask

  task automatic check_regs();
    exp_force_fan = ctl_mem[addr_ctl_flag][CTL_FLAG_FORCE_FAN_BIT];
    exp_sync = ctl_mem[addr_ctl_flag][CTL_FLAG_SYNC_BIT];
    exp_mod_cycle = ctl_mem[addr_mod_cycle];
    exp_mod_freq_div = {ctl_mem[addr_mod_freq_div_1], ctl_mem[addr_mod_freq_div_0]};
    exp_silent_step = ctl_mem[addr_silent_step][SILENT_STEP_W-1:0];
    exp_stm_cycle = ctl_mem[addr_stm_cycle];
    exp_stm_freq_div = {ctl_mem[addr_stm_freq_div_1], ctl_mem[addr_stm_freq_div_0]};
    exp_sound_speed = {ctl_mem[addr_sound_speed_1], ctl_mem[addr_sound_speed_0]};
    exp_stm_start_idx = ctl_mem[addr_stm_start_idx];
    exp_stm_finish_idx = ctl_mem[addr_stm_finish_idx];
    exp_ec_sync_time = {ctl_mem[addr_ec_sync_time_3], ctl_mem[addr_ec_sync_time_2],
                        ctl_mem[addr_ec_sync_time_1], ctl_mem[addr_ec_sync_time_0]};
    regs_chk = 1'b1;
    @(negedge CPU_CKIO);
    regs_chk = 1'b0;
  endtask

  task automatic end_test(input int n);
    test_num = n;
    test_done = 1'b1;
    @(negedge CPU_CKIO);
    test_done = 1'b0;
  endtask

  // Same word addresses on every page with data tagged by the page
  task automatic page_test(input bram_select_t sel, input ctl_addr_t page_reg, input int pages);
    for (int p = 0; p < pages; p++) begin
      bus_write(bram_select_controller, BUS_ADDR_W'(page_reg), 16'(p));
      for (int i = 0; i < 8; i++) begin
        bus_write(sel, edge_addr(i), {p[3:0], 4'(i), 8'($urandom)});
      end
    end
    for (int p = 0; p < pages; p++) begin
      bus_write(bram_select_controller, BUS_ADDR_W'(page_reg), 16'(p));
      for (int i = 0; i < 8; i++) begin
        bus_read(sel, edge_addr(i));
      end
    end
  endtask

  initial begin
    CPU_CKIO = 1'b0;
    rst_n = 1'b0;
    cpu_addr = '0;
    cpu_data = '0;
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    rd_chk = 1'b0;
    rd_exp = '0;
    regs_chk = 1'b0;
    test_done = 1'b0;
    test_num = 0;
    run_done = 1'b0;
    seed_val = 32'h2f87;
    r = $urandom(seed_val);
    for (int i = 0; i < 256; i++) begin
      ctl_mem[i] = '0;
    end
    check_regs_clear();
    repeat (16) @(negedge CPU_CKIO);
    rst_n = 1'b1;
    @(negedge CPU_CKIO);

    expect_read(16'h0000);
    check_regs();
    for (int i = 0; i < 256; i++) begin
      if (ctl_mask(i[7:0]) != '0) bus_read(bram_select_controller, BUS_ADDR_W'(i));
    end
    end_test(1);

    for (int i = 0; i < 256; i++) begin
      if (ctl_mask(i[7:0]) != '0) begin
        bus_write(bram_select_controller, BUS_ADDR_W'(i), 16'($urandom));
      end
    end
    for (int i = 0; i < 256; i++) begin
      if (ctl_mask(i[7:0]) != '0) bus_read(bram_select_controller, BUS_ADDR_W'(i));
    end
    check_regs();
    // 0x121 sits above the map and must not touch mod_cycle
    bus_write(bram_select_controller, 14'h030, 16'hbeef);
    bus_read(bram_select_controller, 14'h030);
    bus_write(bram_select_controller, 14'h121, 16'h1234);
    bus_read(bram_select_controller, 14'h121);
    bus_read(bram_select_controller, 14'h105);
    check_regs();
    end_test(2);

    for (int i = 0; i < NORMAL_WORDS; i++) begin
      bus_write(bram_select_normal, BUS_ADDR_W'(i), 16'($urandom));
    end
    bus_write(bram_select_normal, BUS_ADDR_W'(NORMAL_WORDS), 16'h5a5a);
    bus_write(bram_select_normal, 14'h0ff, 16'ha5a5);
    for (int i = 0; i < NORMAL_WORDS; i++) begin
      bus_read(bram_select_normal, BUS_ADDR_W'(i));
    end
    bus_read(bram_select_normal, BUS_ADDR_W'(NORMAL_WORDS));
    bus_read(bram_select_normal, 14'h0ff);
    end_test(3);

    page_test(bram_select_mod, addr_mod_mem_page, 2 ** MOD_PAGE_BITS);
    end_test(4);
    page_test(bram_select_stm, addr_stm_mem_page, 2 ** STM_PAGE_BITS);
    end_test(5);

    // Paged reads stay on the edge words that every page already holds
    for (int n = 0; n < 200; n++) begin
      if (n % 10 == 0) begin
        bus_write(bram_select_controller, BUS_ADDR_W'(addr_mod_mem_page), 16'($urandom));
        bus_write(bram_select_controller, BUS_ADDR_W'(addr_stm_mem_page), 16'($urandom));
      end
      r = $urandom;
      region = bram_select_t'(r[1:0]);
      case (region)
        bram_select_mod, bram_select_stm: a = edge_addr(int'(r[10:8]));
        default: a = {6'd0, r[15:8]};
      endcase
      if (r[4]) begin
        bus_write(region, a, r[31:16]);
      end else begin
        bus_read(region, a);
      end
    end
    check_regs();
    end_test(6);

    run_done = 1'b1;
    wait (reported);
    if (err_total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  task automatic check_regs_clear();
    exp_force_fan = 1'b0;
    exp_sync = 1'b0;
    exp_mod_cycle = '0;
    exp_mod_freq_div = '0;
    exp_silent_step = '0;
    exp_stm_cycle = '0;
    exp_stm_freq_div = '0;
    exp_sound_speed = '0;
    exp_stm_start_idx = '0;
    exp_stm_finish_idx = '0;
    exp_ec_sync_time = '0;
  endtask

  initial begin
    #((NUM_ACCESSES * ACCESS_CYCLES + 16 + 1000) * CLK_PERIOD);
    $display("Timeout: the run did not reach its end within the expected number of cycles");
    $display("Test failed");
    $finish;
  end

endmodule

// File: sim/bram_checker.sv
`timescale 1ns/1ps
module bram_checker (
  input  logic                               CPU_CKIO,
  input  logic [bus_pkg::BUS_ADDR_W+2:0]     cpu_addr,
  input  logic [bus_pkg::DATA_W-1:0]         cpu_data_read,
  input  logic                               force_fan,
  input  logic                               sync,
  input  logic [15:0]                        mod_cycle,
  input  logic [31:0]                        mod_freq_div,
  input  logic [ctl_pkg::SILENT_STEP_W-1:0]  silent_step,
  input  logic [15:0]                        stm_cycle,
  input  logic [31:0]                        stm_freq_div,
  input  logic [31:0]                        sound_speed,
  input  logic [15:0]                        stm_start_idx,
  input  logic [15:0]                        stm_finish_idx,
  input  logic [63:0]                        ec_sync_time,
  input  logic                               rd_chk,
  input  logic [bus_pkg::DATA_W-1:0]         rd_exp,
  input  logic                               regs_chk,
  input  logic                               exp_force_fan,
  input  logic                               exp_sync,
  input  logic [15:0]                        exp_mod_cycle,
  input  logic [31:0]                        exp_mod_freq_div,
  input  logic [ctl_pkg::SILENT_STEP_W-1:0]  exp_silent_step,
  input  logic [15:0]                        exp_stm_cycle,
  input  logic [31:0]                        exp_stm_freq_div,
  input  logic [31:0]                        exp_sound_speed,
  input  logic [15:0]                        exp_stm_start_idx,
  input  logic [15:0]                        exp_stm_finish_idx,
  input  logic [63:0]                        exp_ec_sync_time,
  input  logic                               test_done,
  input  int                                 test_num,
  input  logic                               run_done,
  output int                                 err_total,
  output logic                               reported
);

  int test_checks;
  int test_errs;
  int total_checks;

  initial begin
    test_checks = 0;
    test_errs = 0;
    total_checks = 0;
    err_total = 0;
    reported = 1'b0;
  end

  function automatic string test_name(input int n);
    case (n)
      1:       return "reset_values";
      2:       return "ctl_registers";
      3:       return "normal_bank";
      4:       return "mod_paging";
      5:       return "stm_paging";
      6:       return "mixed_traffic";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    test_checks++;
    total_checks++;
    if (got !== exp) begin
      test_errs++;
      err_total++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h (cpu_addr 0x%0h, %0t)",
               name, got, exp, cpu_addr, $time);
    end
  endtask

  // Samples on the rising edge, stimulus moved on the falling edge before it
  always @(posedge CPU_CKIO) begin
    if (rd_chk) begin
      compare("cpu_data_read", 64'(cpu_data_read), 64'(rd_exp));
    end
    if (regs_chk) begin
      compare("force_fan", 64'(force_fan), 64'(exp_force_fan));
      compare("sync", 64'(sync), 64'(exp_sync));
      compare("mod_cycle", 64'(mod_cycle), 64'(exp_mod_cycle));
      compare("mod_freq_div", 64'(mod_freq_div), 64'(exp_mod_freq_div));
      compare("silent_step", 64'(silent_step), 64'(exp_silent_step));
      compare("stm_cycle", 64'(stm_cycle), 64'(exp_stm_cycle));
      compare("stm_freq_div", 64'(stm_freq_div), 64'(exp_stm_freq_div));
      compare("sound_speed", 64'(sound_speed), 64'(exp_sound_speed));
      compare("stm_start_idx", 64'(stm_start_idx), 64'(exp_stm_start_idx));
      compare("stm_finish_idx", 64'(stm_finish_idx), 64'(exp_stm_finish_idx));
      compare("ec_sync_time", ec_sync_time, exp_ec_sync_time);
    end
    if (test_done) begin
      $display("test %0d %s: %0d checks, %0d errors",
               test_num, test_name(test_num), test_checks, test_errs);
      test_checks = 0;
      test_errs = 0;
    end
    if (run_done && !reported) begin
      $display("Summary: %0d checks, %0d errors", total_checks, err_total);
      reported = 1'b1;
    end
  end

endmodule

// File: logic/cpu_bram_top.sv
`timescale 1ns/1ps
module cpu_bram_top #(
  parameter int MOD_PAGE_W = bus_pkg::MOD_PAGE_W,
  parameter int STM_PAGE_W = bus_pkg::STM_PAGE_W,
  parameter int NORMAL_DEPTH = bus_pkg::NORMAL_DEPTH
) (
  input  logic                            CPU_CKIO,
  input  logic                            rst_n,
  input  logic [bus_pkg::BUS_ADDR_W+2:0]  cpu_addr,
  input  logic [bus_pkg::DATA_W-1:0]      cpu_data,
  input  logic                            cpu_cs1_n,
  input  logic                            cpu_we0_n,
  output logic [bus_pkg::DATA_W-1:0]      cpu_data_read,
  output logic                            force_fan,
  output logic                            sync,
  output logic [15:0]                     mod_cycle,
  output logic [31:0]                     mod_freq_div,
  output logic [ctl_pkg::SILENT_STEP_W-1:0] silent_step,
  output logic [15:0]                     stm_cycle,
  output logic [31:0]                     stm_freq_div,
  output logic [31:0]                     sound_speed,
  output logic [15:0]                     stm_start_idx,
  output logic [15:0]                     stm_finish_idx,
  output logic [63:0]                     ec_sync_time
);
  import bus_pkg::*;

  localparam int ADDR_W = BUS_ADDR_W + (MOD_PAGE_W > STM_PAGE_W ? MOD_PAGE_W : STM_PAGE_W);
  localparam int NORMAL_ADDR_W = 8;
  localparam int MOD_ADDR_W = BUS_ADDR_W + MOD_PAGE_W;
  localparam int STM_ADDR_W = BUS_ADDR_W + STM_PAGE_W;

  logic              wr_en_ctl;
  logic              wr_en_mod;
  logic              wr_en_normal;
  logic              wr_en_stm;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data_ctl;
  logic [DATA_W-1:0] rd_data_mod;
  logic [DATA_W-1:0] rd_data_normal;
  logic [DATA_W-1:0] rd_data_stm;
  logic [MOD_PAGE_W-1:0] mod_page;
  logic [STM_PAGE_W-1:0] stm_page;

  cpu_bus_bridge #(
    .MOD_PAGE_W(MOD_PAGE_W),
    .STM_PAGE_W(STM_PAGE_W)
  ) u_bridge (
    .CPU_CKIO(CPU_CKIO), .rst_n(rst_n),
    .cpu_addr(cpu_addr), .cpu_data(cpu_data),
    .cpu_cs1_n(cpu_cs1_n), .cpu_we0_n(cpu_we0_n),
    .mod_page(mod_page), .stm_page(stm_page),
    .rd_data_ctl(rd_data_ctl), .rd_data_mod(rd_data_mod),
    .rd_data_normal(rd_data_normal), .rd_data_stm(rd_data_stm),
    .cpu_data_read(cpu_data_read),
    .wr_en_ctl(wr_en_ctl), .wr_en_mod(wr_en_mod),
    .wr_en_normal(wr_en_normal), .wr_en_stm(wr_en_stm),
    .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr)
  );

  ctl_regs #(
    .MOD_PAGE_W(MOD_PAGE_W),
    .STM_PAGE_W(STM_PAGE_W)
  ) u_ctl_regs (
    .CPU_CKIO(CPU_CKIO), .rst_n(rst_n), .wr_en(wr_en_ctl),
    .wr_addr(wr_addr[BUS_ADDR_W-1:0]), .wr_data(wr_data),
    .rd_addr(rd_addr[BUS_ADDR_W-1:0]), .rd_data(rd_data_ctl),
    .mod_page(mod_page), .stm_page(stm_page),
    .force_fan(force_fan), .sync(sync),
    .mod_cycle(mod_cycle), .mod_freq_div(mod_freq_div),
    .silent_step(silent_step), .stm_cycle(stm_cycle),
    .stm_freq_div(stm_freq_div), .sound_speed(sound_speed),
    .stm_start_idx(stm_start_idx), .stm_finish_idx(stm_finish_idx),
    .ec_sync_time(ec_sync_time)
  );

  // One word per transducer
  bank_ram #(.ADDR_W(NORMAL_ADDR_W), .DEPTH(NORMAL_DEPTH)) u_normal_ram (
    .CPU_CKIO(CPU_CKIO), .wr_en(wr_en_normal),
    .wr_addr(wr_addr[NORMAL_ADDR_W-1:0]), .wr_data(wr_data),
    .rd_addr(rd_addr[NORMAL_ADDR_W-1:0]), .rd_data(rd_data_normal)
  );

  bank_ram #(.ADDR_W(MOD_ADDR_W)) u_mod_ram (
    .CPU_CKIO(CPU_CKIO), .wr_en(wr_en_mod),
    .wr_addr(wr_addr[MOD_ADDR_W-1:0]), .wr_data(wr_data),
    .rd_addr(rd_addr[MOD_ADDR_W-1:0]), .rd_data(rd_data_mod)
  );

  bank_ram #(.ADDR_W(STM_ADDR_W)) u_stm_ram (
    .CPU_CKIO(CPU_CKIO), .wr_en(wr_en_stm),
    .wr_addr(wr_addr[STM_ADDR_W-1:0]), .wr_data(wr_data),
    .rd_addr(rd_addr[STM_ADDR_W-1:0]), .rd_data(rd_data_stm)
  );

endmodule

// File: logic/cpu_bus_bridge.sv
`timescale 1ns/1ps
module cpu_bus_bridge #(
  parameter int MOD_PAGE_W = bus_pkg::MOD_PAGE_W,
  parameter int STM_PAGE_W = bus_pkg::STM_PAGE_W,
  localparam int ADDR_W = bus_pkg::BUS_ADDR_W + (MOD_PAGE_W > STM_PAGE_W ? MOD_PAGE_W : STM_PAGE_W)
) (
  input  logic                        CPU_CKIO,
  input  logic                        rst_n,
  input  logic [bus_pkg::BUS_ADDR_W+2:0] cpu_addr,
  input  logic [bus_pkg::DATA_W-1:0]  cpu_data,
  input  logic                        cpu_cs1_n,
  input  logic                        cpu_we0_n,
  input  logic [MOD_PAGE_W-1:0]       mod_page,
  input  logic [STM_PAGE_W-1:0]       stm_page,
  input  logic [bus_pkg::DATA_W-1:0]  rd_data_ctl,
  input  logic [bus_pkg::DATA_W-1:0]  rd_data_mod,
  input  logic [bus_pkg::DATA_W-1:0]  rd_data_normal,
  input  logic [bus_pkg::DATA_W-1:0]  rd_data_stm,
  output logic [bus_pkg::DATA_W-1:0]  cpu_data_read,
  output logic                        wr_en_ctl,
  output logic                        wr_en_mod,
  output logic                        wr_en_normal,
  output logic                        wr_en_stm,
  output logic [ADDR_W-1:0]           wr_addr,
  output logic [bus_pkg::DATA_W-1:0]  wr_data,
  output logic [ADDR_W-1:0]           rd_addr
);
  import bus_pkg::*;

  logic [BUS_ADDR_W+1:0] addr_q;
  logic [DATA_W-1:0]     data_q;
  logic                  en_q;
  logic                  we_q;
  logic                  we_prev;
  logic                  wr_stb;
  logic                  rd_vld;
  logic                  rd_vld_d;
  bram_select_t          sel_q;
  bram_select_t          sel_d;
  logic [ADDR_W-1:0]     full_addr;

  // Bus pins sampled once, bit 0 of the address is not used
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= 1'b0;
      we_q <= 1'b0;
      we_prev <= 1'b0;
    end else begin
      en_q <= ~cpu_cs1_n;
      we_q <= ~cpu_we0_n;
      we_prev <= we_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr[BUS_ADDR_W+2:1];
    data_q <= cpu_data;
  end

  assign sel_q = bram_select_t'(addr_q[BUS_ADDR_W+1:BUS_ADDR_W]);
  assign wr_stb = en_q & we_q & ~we_prev;
  assign rd_vld = en_q & ~we_q;

  // Page registers extend the mod and STM windows
  always_comb begin
    full_addr = '0;
    full_addr[BUS_ADDR_W-1:0] = addr_q[BUS_ADDR_W-1:0];
    case (sel_q)
      bram_select_mod: full_addr[BUS_ADDR_W+:MOD_PAGE_W] = mod_page;
      bram_select_stm: full_addr[BUS_ADDR_W+:STM_PAGE_W] = stm_page;
      default: ;
    endcase
  end

  assign rd_addr = full_addr;

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_ctl <= 1'b0;
      wr_en_mod <= 1'b0;
      wr_en_normal <= 1'b0;
      wr_en_stm <= 1'b0;
      sel_d <= bram_select_controller;
      rd_vld_d <= 1'b0;
      cpu_data_read <= '0;
    end else begin
      wr_en_ctl <= wr_stb && (sel_q == bram_select_controller);
      wr_en_mod <= wr_stb && (sel_q == bram_select_mod);
      wr_en_normal <= wr_stb && (sel_q == bram_select_normal);
      wr_en_stm <= wr_stb && (sel_q == bram_select_stm);
      // Region follows the bank read by one cycle
      sel_d <= sel_q;
      rd_vld_d <= rd_vld;
      if (rd_vld_d) begin
        case (sel_d)
          bram_select_controller: cpu_data_read <= rd_data_ctl;
          bram_select_mod:        cpu_data_read <= rd_data_mod;
          bram_select_normal:     cpu_data_read <= rd_data_normal;
          default:                cpu_data_read <= rd_data_stm;
        endcase
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    wr_addr <= full_addr;
    wr_data <= data_q;
  end

endmodule

// File: logic/ctl_regs.sv
`timescale 1ns/1ps
module ctl_regs #(
  parameter int MOD_PAGE_W = bus_pkg::MOD_PAGE_W,
  parameter int STM_PAGE_W = bus_pkg::STM_PAGE_W
) (
  input  logic                            CPU_CKIO,
  input  logic                            rst_n,
  input  logic                            wr_en,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]  wr_addr,
  input  logic [bus_pkg::DATA_W-1:0]      wr_data,
  input  logic [bus_pkg::BUS_ADDR_W-1:0]  rd_addr,
  output logic [bus_pkg::DATA_W-1:0]      rd_data,
  output logic [MOD_PAGE_W-1:0]           mod_page,
  output logic [STM_PAGE_W-1:0]           stm_page,
  output logic                            force_fan,
  output logic                            sync,
  output logic [15:0]                     mod_cycle,
  output logic [31:0]                     mod_freq_div,
  output logic [ctl_pkg::SILENT_STEP_W-1:0] silent_step,
  output logic [15:0]                     stm_cycle,
  output logic [31:0]                     stm_freq_div,
  output logic [31:0]                     sound_speed,
  output logic [15:0]                     stm_start_idx,
  output logic [15:0]                     stm_finish_idx,
  output logic [63:0]                     ec_sync_time
);
  import bus_pkg::*;
  import ctl_pkg::*;

  logic              wr_hit;
  logic              rd_hit;
  logic [DATA_W-1:0] flag_word;
  logic [DATA_W-1:0] rd_word;

  // Map occupies the low 256 words, anything above is unmapped
  assign wr_hit = wr_en && (wr_addr[BUS_ADDR_W-1:8] == '0);
  assign rd_hit = rd_addr[BUS_ADDR_W-1:8] == '0;

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      force_fan <= 1'b0;
      sync <= 1'b0;
      mod_page <= '0;
      stm_page <= '0;
      mod_cycle <= '0;
      mod_freq_div <= '0;
      silent_step <= '0;
      stm_cycle <= '0;
      stm_freq_div <= '0;
      sound_speed <= '0;
      stm_start_idx <= '0;
      stm_finish_idx <= '0;
      ec_sync_time <= '0;
    end else if (wr_hit) begin
      case (ctl_addr_t'(wr_addr[7:0]))
        addr_ctl_flag: begin
          force_fan <= wr_data[CTL_FLAG_FORCE_FAN_BIT];
          sync <= wr_data[CTL_FLAG_SYNC_BIT];
        end
        addr_mod_mem_page:   mod_page <= wr_data[MOD_PAGE_W-1:0];
        addr_stm_mem_page:   stm_page <= wr_data[STM_PAGE_W-1:0];
        addr_mod_cycle:      mod_cycle <= wr_data;
        addr_mod_freq_div_0: mod_freq_div[15:0] <= wr_data;
        addr_mod_freq_div_1: mod_freq_div[31:16] <= wr_data;
        addr_silent_step:    silent_step <= wr_data[SILENT_STEP_W-1:0];
        addr_stm_cycle:      stm_cycle <= wr_data;
        addr_stm_freq_div_0: stm_freq_div[15:0] <= wr_data;
        addr_stm_freq_div_1: stm_freq_div[31:16] <= wr_data;
        addr_sound_speed_0:  sound_speed[15:0] <= wr_data;
        addr_sound_speed_1:  sound_speed[31:16] <= wr_data;
        addr_stm_start_idx:  stm_start_idx <= wr_data;
        addr_stm_finish_idx: stm_finish_idx <= wr_data;
        addr_ec_sync_time_0: ec_sync_time[15:0] <= wr_data;
        addr_ec_sync_time_1: ec_sync_time[31:16] <= wr_data;
        addr_ec_sync_time_2: ec_sync_time[47:32] <= wr_data;
        addr_ec_sync_time_3: ec_sync_time[63:48] <= wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    flag_word = '0;
    flag_word[CTL_FLAG_FORCE_FAN_BIT] = force_fan;
    flag_word[CTL_FLAG_SYNC_BIT] = sync;
  end

  // Readback, unused bits come back as zero
  always_comb begin
    rd_word = '0;
    if (rd_hit) begin
      case (ctl_addr_t'(rd_addr[7:0]))
        addr_ctl_flag:       rd_word = flag_word;
        addr_mod_mem_page:   rd_word = DATA_W'(mod_page);
        addr_stm_mem_page:   rd_word = DATA_W'(stm_page);
        addr_mod_cycle:      rd_word = mod_cycle;
        addr_mod_freq_div_0: rd_word = mod_freq_div[15:0];
        addr_mod_freq_div_1: rd_word = mod_freq_div[31:16];
        addr_silent_step:    rd_word = DATA_W'(silent_step);
        addr_stm_cycle:      rd_word = stm_cycle;
        addr_stm_freq_div_0: rd_word = stm_freq_div[15:0];
        addr_stm_freq_div_1: rd_word = stm_freq_div[31:16];
        addr_sound_speed_0:  rd_word = sound_speed[15:0];
        addr_sound_speed_1:  rd_word = sound_speed[31:16];
        addr_stm_start_idx:  rd_word = stm_start_idx;
        addr_stm_finish_idx: rd_word = stm_finish_idx;
        addr_ec_sync_time_0: rd_word = ec_sync_time[15:0];
        addr_ec_sync_time_1: rd_word = ec_sync_time[31:16];
        addr_ec_sync_time_2: rd_word = ec_sync_time[47:32];
        addr_ec_sync_time_3: rd_word = ec_sync_time[63:48];
        default:             rd_word = '0;
      endcase
    end
  end

  // Registered like a bank read so the bridge mux lines up
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else begin
      rd_data <= rd_word;
    end
  end

endmodule

// File: logic/bank_ram.sv
`timescale 1ns/1ps
module bank_ram #(
  parameter int ADDR_W = bus_pkg::BUS_ADDR_W,
  parameter int DEPTH = 2 ** ADDR_W
) (
  input  logic                       CPU_CKIO,
  input  logic                       wr_en,
  input  logic [ADDR_W-1:0]          wr_addr,
  input  logic [bus_pkg::DATA_W-1:0] wr_data,
  input  logic [ADDR_W-1:0]          rd_addr,
  output logic [bus_pkg::DATA_W-1:0] rd_data
);
  import bus_pkg::*;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && (wr_addr < DEPTH)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Words past the end read as zero
  always_ff @(posedge CPU_CKIO) begin
    if (rd_addr < DEPTH) begin
      rd_data <= mem[rd_addr];
    end else begin
      rd_data <= '0;
    end
  end

endmodule

// File: logic/ctl_pkg.sv
package ctl_pkg;

  // Controller register map, word addresses inside the controller region
  typedef enum logic [7:0] {
    addr_ctl_flag        = 8'h00,
    addr_ec_sync_time_0  = 8'h11,
    addr_ec_sync_time_1  = 8'h12,
    addr_ec_sync_time_2  = 8'h13,
    addr_ec_sync_time_3  = 8'h14,
    addr_mod_mem_page    = 8'h20,
    addr_mod_cycle       = 8'h21,
    addr_mod_freq_div_0  = 8'h22,
    addr_mod_freq_div_1  = 8'h23,
    addr_silent_step     = 8'h40,
    addr_stm_mem_page    = 8'h50,
    addr_stm_cycle       = 8'h51,
    addr_stm_freq_div_0  = 8'h52,
    addr_stm_freq_div_1  = 8'h53,
    addr_sound_speed_0   = 8'h54,
    addr_sound_speed_1   = 8'h55,
    addr_stm_start_idx   = 8'h56,
    addr_stm_finish_idx  = 8'h57
  } ctl_addr_t;

  // Bits in ctl_flag
  localparam int CTL_FLAG_FORCE_FAN_BIT = 0;
  localparam int CTL_FLAG_SYNC_BIT = 1;

  // Width of silent_step after truncation
  localparam int SILENT_STEP_W = 9;

endpackage

// File: logic/bus_pkg.sv
package bus_pkg;

  // CPU bus word and in-region word address
  localparam int DATA_W = 16;
  localparam int BUS_ADDR_W = 14;

  // Page widths that extend the mod and STM windows
  localparam int MOD_PAGE_W = 1;
  localparam int STM_PAGE_W = 2;

  // One intensity/phase word per transducer
  localparam int NORMAL_DEPTH = 249;

  // Region select, taken from the two top address bits
  typedef enum logic [1:0] {
    bram_select_controller = 2'd0,
    bram_select_mod        = 2'd1,
    bram_select_normal     = 2'd2,
    bram_select_stm        = 2'd3
  } bram_select_t;

endpackage
